// ==== flash_cmd_pkg.sv ====
package flash_cmd_pkg;

  localparam int ADDR_W    = 25;  // word address
  localparam int DATA_W    = 16;
  localparam int LEN_W     = 10;  // word count minus one
  localparam int BLOCK_LSB = 17;
  localparam int BUF_DEPTH = 512;
  localparam int BUF_AW    = $clog2(BUF_DEPTH);

  localparam logic [DATA_W-1:0] CMD_BUF_PROG   = 16'h00e9;
  localparam logic [DATA_W-1:0] CMD_CONFIRM    = 16'h00d0;
  localparam logic [DATA_W-1:0] CMD_READ_ARRAY = 16'h00ff;

  // status register layout, low byte is the real status
  typedef struct packed {
    logic [7:0] rsvd_hi;
    logic       ready;      // write state machine ready
    logic       rsvd6;
    logic       erase_err;
    logic       prog_err;
    logic       vpp_err;
    logic       rsvd2;
    logic       lock_err;   // block was locked
    logic       rsvd0;
  } flash_status_t;

  // one word off the dq pins, read as array data or as status
  typedef union packed {
    logic [DATA_W-1:0] raw;
    flash_status_t     status;
  } flash_rd_word_u;

endpackage

// ==== flash_bus_pkg.sv ====
package flash_bus_pkg;

  // write strobe timing in clocks
  localparam int WE_LOW_CYC  = 3;
  localparam int WE_HIGH_CYC = 2;   // recovery before next cycle

  // oe_n low to data sample
  localparam int RD_ACC_CYC = 4;

  // phase counter has to reach the longest of the above
  localparam int PHASE_W = 3;

  // confirm done to first status read
  localparam int POLL_WAIT_CYC = 20;
  localparam int POLL_CNT_W    = $clog2(POLL_WAIT_CYC);

endpackage

// ==== flash_bus_if.sv ====
`timescale 1ns/1ps

interface flash_bus_if
  import flash_cmd_pkg::*;
();

  logic              wr_en;
  logic [ADDR_W-1:0] wr_addr;
  logic [DATA_W-1:0] wr_data;
  logic              wr_done;

  logic              rd_en;
  logic [ADDR_W-1:0] rd_addr;
  logic [DATA_W-1:0] rd_data;   // valid with rd_done
  logic              rd_done;

  modport seq (
    output wr_en, wr_addr, wr_data, rd_en, rd_addr,
    input  wr_done, rd_done, rd_data
  );

  modport eng (
    input  wr_en, wr_addr, wr_data, rd_en, rd_addr,
    output wr_done, rd_done, rd_data
  );

endinterface

// ==== prog_buf_fifo.sv ====
`timescale 1ns/1ps

module prog_buf_fifo
  import flash_cmd_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              wr_en,
  input  logic [DATA_W-1:0] wr_data,
  output logic              full,
  input  logic              rd_en,
  output logic [DATA_W-1:0] rd_data,
  output logic              rd_valid
);

  logic [DATA_W-1:0] mem [BUF_DEPTH];
  logic [BUF_AW-1:0] wr_ptr;
  logic [BUF_AW-1:0] rd_ptr;
  logic [BUF_AW:0]   count;
  logic              wr_ok;
  logic              rd_ok;

  assign full  = (count == (BUF_AW + 1)'(BUF_DEPTH));
  assign wr_ok = wr_en && !full;      // drop when full
  assign rd_ok = rd_en && (count != '0);

  always_ff @(posedge clk)
  begin
    if (wr_ok)
      mem[wr_ptr] <= wr_data;
    if (rd_ok)
      rd_data <= mem[rd_ptr];
  end

  // pointers wrap on their own, depth is a power of two
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      rd_valid <= 1'b0;
    end
    else
    begin
      rd_valid <= rd_ok;
      if (wr_ok)
        wr_ptr <= wr_ptr + 1'b1;
      if (rd_ok)
        rd_ptr <= rd_ptr + 1'b1;
      if (wr_ok && !rd_ok)
        count <= count + 1'b1;
      else if (rd_ok && !wr_ok)
        count <= count - 1'b1;
    end
  end

endmodule

// ==== buf_prog_seq.sv ====
`timescale 1ns/1ps

module buf_prog_seq
  import flash_cmd_pkg::*;
  import flash_bus_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              prog_en,
  input  logic [ADDR_W-1:0] prog_addr,
  input  logic [LEN_W-1:0]  prog_length,
  output logic              prog_done,
  output logic              prog_busy,
  output logic [7:0]        prog_status,
  output logic              buf_rd_en,
  input  logic [DATA_W-1:0] buf_rd_data,
  input  logic              buf_rd_valid,
  flash_bus_if.seq          bus
);

  // one-hot state bits
  localparam int S_IDLE  = 0;
  localparam int S_SET   = 1;   // 0xE9 to block
  localparam int S_COUNT = 2;
  localparam int S_WORD  = 3;
  localparam int S_CONF  = 4;
  localparam int S_WAIT  = 5;
  localparam int S_STAT  = 6;
  localparam int S_RDARR = 7;

  logic [7:0]            state;
  logic [ADDR_W-1:0]     start_addr;
  logic [ADDR_W-1:0]     blk_addr;
  logic [ADDR_W-1:0]     cur_addr;
  logic [LEN_W-1:0]      len;
  logic [LEN_W-1:0]      word_cnt;
  logic [POLL_CNT_W-1:0] wait_cnt;
  logic                  want;       // a buffer word is still owed
  logic                  last_word;
  flash_rd_word_u        rd_word;

  assign rd_word   = bus.rd_data;
  assign last_word = (word_cnt == len);
  assign prog_busy = !state[S_IDLE];

  // status polls go to the block
  assign bus.rd_addr = blk_addr;

  always_comb
  begin
    bus.wr_addr = start_addr;
    bus.wr_data = CMD_READ_ARRAY;
    case (1'b1)
      state[S_SET]:
      begin
        bus.wr_addr = blk_addr;
        bus.wr_data = CMD_BUF_PROG;
      end
      state[S_COUNT]:
        bus.wr_data = {{(DATA_W - LEN_W){1'b0}}, len};
      state[S_WORD]:
      begin
        bus.wr_addr = cur_addr;
        bus.wr_data = buf_rd_data;   // fifo holds it until the next read
      end
      state[S_CONF]:
        bus.wr_data = CMD_CONFIRM;
      default:
        ;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (state[S_IDLE] && prog_en)
    begin
      start_addr <= prog_addr;
      blk_addr   <= {prog_addr[ADDR_W-1:BLOCK_LSB], {BLOCK_LSB{1'b0}}};
      len        <= prog_length;
    end
    if (state[S_COUNT] && bus.wr_done)
    begin
      cur_addr <= start_addr;
      word_cnt <= '0;
    end
    else if (state[S_WORD] && bus.wr_done)
    begin
      cur_addr <= cur_addr + 1'b1;
      word_cnt <= word_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state       <= 8'd1 << S_IDLE;
      bus.wr_en   <= 1'b0;
      bus.rd_en   <= 1'b0;
      buf_rd_en   <= 1'b0;
      want        <= 1'b0;
      wait_cnt    <= '0;
      prog_done   <= 1'b0;
      prog_status <= '0;
    end
    else
    begin
      bus.wr_en <= 1'b0;
      bus.rd_en <= 1'b0;
      buf_rd_en <= 1'b0;
      prog_done <= 1'b0;
      case (1'b1)
        state[S_IDLE]:
          if (prog_en)
          begin
            state     <= 8'd1 << S_SET;
            bus.wr_en <= 1'b1;
          end
        state[S_SET]:
          if (bus.wr_done)
          begin
            state     <= 8'd1 << S_COUNT;
            bus.wr_en <= 1'b1;
          end
        state[S_COUNT]:
          if (bus.wr_done)
          begin
            state <= 8'd1 << S_WORD;
            want  <= 1'b1;
          end
        state[S_WORD]:
        begin
          // retry every other cycle while the buffer is empty
          buf_rd_en <= want && !buf_rd_en && !buf_rd_valid;
          if (buf_rd_valid)
          begin
            want      <= 1'b0;
            bus.wr_en <= 1'b1;
          end
          if (bus.wr_done)
          begin
            if (last_word)
            begin
              state     <= 8'd1 << S_CONF;
              bus.wr_en <= 1'b1;
            end
            else
              want <= 1'b1;
          end
        end
        state[S_CONF]:
          if (bus.wr_done)
          begin
            state    <= 8'd1 << S_WAIT;
            wait_cnt <= '0;
          end
        state[S_WAIT]:
          if (wait_cnt == POLL_CNT_W'(POLL_WAIT_CYC - 1))
          begin
            state     <= 8'd1 << S_STAT;
            bus.rd_en <= 1'b1;
          end
          else
            wait_cnt <= wait_cnt + 1'b1;
        state[S_STAT]:
          if (bus.rd_done)
          begin
            if (rd_word.status.ready)
            begin
              prog_status <= rd_word.raw[7:0];
              state       <= 8'd1 << S_RDARR;
              bus.wr_en   <= 1'b1;
            end
            else
              bus.rd_en <= 1'b1;   // poll again
          end
        state[S_RDARR]:
          if (bus.wr_done)
          begin
            state     <= 8'd1 << S_IDLE;
            prog_done <= 1'b1;
          end
        default:
          state <= 8'd1 << S_IDLE;
      endcase
    end
  end

endmodule

// ==== flash_bus_engine.sv ====
`timescale 1ns/1ps

module flash_bus_engine
  import flash_cmd_pkg::*;
  import flash_bus_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  flash_bus_if.eng          bus,
  output logic [ADDR_W-1:0] flash_addr,
  output logic [DATA_W-1:0] flash_dq_out,
  output logic              flash_dq_oe,
  input  logic [DATA_W-1:0] flash_dq_in,
  output logic              flash_ce_n,
  output logic              flash_we_n,
  output logic              flash_oe_n
);

  logic               wr_act;
  logic               rd_act;
  logic               tail;     // recovery part of the cycle
  logic [PHASE_W-1:0] phase;
  logic               idle;
  logic               rd_sample;

  assign idle      = !wr_act && !rd_act;
  assign rd_sample = rd_act && !tail && (phase == PHASE_W'(RD_ACC_CYC - 1));

  always_ff @(posedge clk)
  begin
    if (idle && bus.wr_en)
    begin
      flash_addr   <= bus.wr_addr;
      flash_dq_out <= bus.wr_data;
    end
    else if (idle && bus.rd_en)
      flash_addr <= bus.rd_addr;
    if (rd_sample)
      bus.rd_data <= flash_dq_in;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_act      <= 1'b0;
      rd_act      <= 1'b0;
      tail        <= 1'b0;
      phase       <= '0;
      flash_ce_n  <= 1'b1;
      flash_we_n  <= 1'b1;
      flash_oe_n  <= 1'b1;
      flash_dq_oe <= 1'b0;
      bus.wr_done <= 1'b0;
      bus.rd_done <= 1'b0;
    end
    else
    begin
      bus.wr_done <= 1'b0;
      bus.rd_done <= 1'b0;
      if (idle)
      begin
        tail  <= 1'b0;
        phase <= '0;
        if (bus.wr_en)
        begin
          wr_act      <= 1'b1;
          flash_ce_n  <= 1'b0;
          flash_we_n  <= 1'b0;
          flash_dq_oe <= 1'b1;
        end
        else if (bus.rd_en)
        begin
          rd_act     <= 1'b1;
          flash_ce_n <= 1'b0;
          flash_oe_n <= 1'b0;
        end
      end
      else if (wr_act)
      begin
        phase <= phase + 1'b1;
        if (!tail && phase == PHASE_W'(WE_LOW_CYC - 1))
        begin
          flash_we_n <= 1'b1;   // flash latches data here
          tail       <= 1'b1;
          phase      <= '0;
        end
        if (tail && phase == '0)
        begin
          flash_ce_n  <= 1'b1;  // data held one clock past we_n
          flash_dq_oe <= 1'b0;
        end
        if (tail && phase == PHASE_W'(WE_HIGH_CYC - 1))
        begin
          wr_act      <= 1'b0;
          bus.wr_done <= 1'b1;
        end
      end
      else if (!tail)
      begin
        phase <= phase + 1'b1;
        if (rd_sample)
        begin
          flash_ce_n <= 1'b1;
          flash_oe_n <= 1'b1;
          tail       <= 1'b1;
        end
      end
      else
      begin
        rd_act      <= 1'b0;    // bus turnaround clock
        bus.rd_done <= 1'b1;
      end
    end
  end

endmodule

// ==== flash_prog_top.sv ====
`timescale 1ns/1ps

module flash_prog_top
  import flash_cmd_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              buf_wr_en,
  input  logic [DATA_W-1:0] buf_wr_data,
  output logic              buf_full,
  input  logic              prog_en,
  input  logic [ADDR_W-1:0] prog_addr,
  input  logic [LEN_W-1:0]  prog_length,
  output logic              prog_done,
  output logic              prog_busy,
  output logic [7:0]        prog_status,
  output logic [ADDR_W-1:0] flash_addr,
  output logic [DATA_W-1:0] flash_dq_out,
  output logic              flash_dq_oe,
  input  logic [DATA_W-1:0] flash_dq_in,
  output logic              flash_ce_n,
  output logic              flash_we_n,
  output logic              flash_oe_n
);

  logic              buf_rd_en;
  logic [DATA_W-1:0] buf_rd_data;
  logic              buf_rd_valid;

  flash_bus_if bus_if ();

  prog_buf_fifo u_buf (
    .clk      (clk),
    .rst_n    (rst_n),
    .wr_en    (buf_wr_en),
    .wr_data  (buf_wr_data),
    .full     (buf_full),
    .rd_en    (buf_rd_en),
    .rd_data  (buf_rd_data),
    .rd_valid (buf_rd_valid)
  );

  buf_prog_seq u_seq (
    .clk          (clk),
    .rst_n        (rst_n),
    .prog_en      (prog_en),
    .prog_addr    (prog_addr),
    .prog_length  (prog_length),
    .prog_done    (prog_done),
    .prog_busy    (prog_busy),
    .prog_status  (prog_status),
    .buf_rd_en    (buf_rd_en),
    .buf_rd_data  (buf_rd_data),
    .buf_rd_valid (buf_rd_valid),
    .bus          (bus_if.seq)
  );

  flash_bus_engine u_eng (
    .clk          (clk),
    .rst_n        (rst_n),
    .bus          (bus_if.eng),
    .flash_addr   (flash_addr),
    .flash_dq_out (flash_dq_out),
    .flash_dq_oe  (flash_dq_oe),
    .flash_dq_in  (flash_dq_in),
    .flash_ce_n   (flash_ce_n),
    .flash_we_n   (flash_we_n),
    .flash_oe_n   (flash_oe_n)
  );

endmodule

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk,
  output logic rst_n
);

  initial
  begin
    clk   = 1'b0;
    rst_n = 1'b0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;   // release away from the active edge
  end

  always #10 clk = ~clk;

endmodule

// ==== tb_flash_model.sv ====
`timescale 1ns/1ps

module tb_flash_model
  import flash_cmd_pkg::*;
  import flash_bus_pkg::*;
#(
  parameter real CLK_NS = 20.0
)
(
  input  logic [ADDR_W-1:0] addr,
  input  logic [DATA_W-1:0] dq_out,
  input  logic              dq_oe,
  output logic [DATA_W-1:0] dq_in,
  input  logic              ce_n,
  input  logic              we_n,
  input  logic              oe_n,
  input  int                busy_polls,
  input  logic [7:0]        err_bits
);

  localparam int M_ARRAY = 0;
  localparam int M_COUNT = 1;
  localparam int M_DATA  = 2;
  localparam int M_CONF  = 3;
  localparam int M_STAT  = 4;

  logic [DATA_W-1:0] mem [logic [ADDR_W-1:0]];
  int                mode        = M_ARRAY;
  logic [ADDR_W-1:0] blk_addr    = '0;
  logic [ADDR_W-1:0] start_addr  = '0;
  int                count_word  = 0;
  int                idx         = 0;
  int                polls_left  = 0;
  bit                ready_given = 1'b0;
  realtime           conf_t      = 0;
  realtime           rd_start    = 0;
  int                stat_reads  = 0;
  int                ff_writes   = 0;
  bit                order_err   = 1'b0;
  bit                early_poll  = 1'b0;
  flash_rd_word_u    rd_word     = 16'hffff;

  assign dq_in = rd_word.raw;

  // address and data are latched on the rising edge of we_n
  always @(posedge we_n)
  begin
    if (ce_n === 1'b0)
    begin
      if (!dq_oe)
        order_err = 1'b1;
      case (mode)
        M_ARRAY:
        begin
          if (dq_out != CMD_BUF_PROG || addr[BLOCK_LSB-1:0] != '0)
            order_err = 1'b1;
          blk_addr = addr;
          mode     = M_COUNT;
        end
        M_COUNT:
        begin
          if (addr[ADDR_W-1:BLOCK_LSB] != blk_addr[ADDR_W-1:BLOCK_LSB])
            order_err = 1'b1;   // count goes to the start address
          start_addr = addr;
          count_word = dq_out;
          idx        = 0;
          mode       = M_DATA;
        end
        M_DATA:
        begin
          if (addr != start_addr + ADDR_W'(idx))
            order_err = 1'b1;
          mem[addr] = dq_out;
          idx++;
          if (idx > count_word)
            mode = M_CONF;
        end
        M_CONF:
        begin
          if (dq_out != CMD_CONFIRM || addr != start_addr)
            order_err = 1'b1;
          conf_t      = $realtime;
          polls_left  = busy_polls;
          ready_given = 1'b0;
          mode        = M_STAT;
        end
        default:
        begin
          if (dq_out != CMD_READ_ARRAY || !ready_given)
            order_err = 1'b1;   // read-array only once ready was seen
          ff_writes++;
          mode = M_ARRAY;
        end
      endcase
    end
  end

  // answer after a short access delay so ce_n and addr have settled
  always @(negedge oe_n)
  begin
    rd_start = $realtime;
    #1;
    if (ce_n === 1'b0 && mode == M_STAT)
    begin
      if (rd_start - conf_t < POLL_WAIT_CYC * CLK_NS)
        early_poll = 1'b1;
      stat_reads++;
      rd_word.raw = '0;
      if (polls_left > 0)
        polls_left--;   // still busy
      else
      begin
        rd_word.status.ready     = 1'b1;
        rd_word.status.erase_err = err_bits[5];
        rd_word.status.prog_err  = err_bits[4];
        rd_word.status.vpp_err   = err_bits[3];
        rd_word.status.lock_err  = err_bits[1];
        ready_given              = 1'b1;
      end
    end
    else if (ce_n === 1'b0)
      rd_word.raw = mem.exists(addr) ? mem[addr] : 16'hffff;
  end

endmodule

// ==== tb_flash_prog.sv ====
`timescale 1ns/1ps

module tb_flash_prog
  import flash_cmd_pkg::*;
();

  localparam int N_TESTS = 6;

  logic              clk;
  logic              rst_n;
  logic              buf_wr_en;
  logic [DATA_W-1:0] buf_wr_data;
  logic              buf_full;
  logic              prog_en;
  logic [ADDR_W-1:0] prog_addr;
  logic [LEN_W-1:0]  prog_length;
  logic              prog_done;
  logic              prog_busy;
  logic [7:0]        prog_status;
  logic [ADDR_W-1:0] flash_addr;
  logic [DATA_W-1:0] flash_dq_out;
  logic              flash_dq_oe;
  logic [DATA_W-1:0] flash_dq_in;
  logic              flash_ce_n;
  logic              flash_we_n;
  logic              flash_oe_n;
  int                busy_polls;
  logic [7:0]        err_bits;

  // per-test settings, drawn before the first test
  int                t_len   [N_TESTS];
  logic [ADDR_W-1:0] t_addr  [N_TESTS];
  int                t_polls [N_TESTS];
  logic [7:0]        t_err   [N_TESTS];
  bit                t_slow  [N_TESTS];
  int                limit_cycles;

  tb_clk_gen u_clk (
    .clk   (clk),
    .rst_n (rst_n)
  );

  flash_prog_top u_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .buf_wr_en    (buf_wr_en),
    .buf_wr_data  (buf_wr_data),
    .buf_full     (buf_full),
    .prog_en      (prog_en),
    .prog_addr    (prog_addr),
    .prog_length  (prog_length),
    .prog_done    (prog_done),
    .prog_busy    (prog_busy),
    .prog_status  (prog_status),
    .flash_addr   (flash_addr),
    .flash_dq_out (flash_dq_out),
    .flash_dq_oe  (flash_dq_oe),
    .flash_dq_in  (flash_dq_in),
    .flash_ce_n   (flash_ce_n),
    .flash_we_n   (flash_we_n),
    .flash_oe_n   (flash_oe_n)
  );

  tb_flash_model u_flash (
    .addr       (flash_addr),
    .dq_out     (flash_dq_out),
    .dq_oe      (flash_dq_oe),
    .dq_in      (flash_dq_in),
    .ce_n       (flash_ce_n),
    .we_n       (flash_we_n),
    .oe_n       (flash_oe_n),
    .busy_polls (busy_polls),
    .err_bits   (err_bits)
  );

  task automatic end_with_failure(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic expect_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    assert (got === exp)
    else
      end_with_failure($sformatf("MISMATCH at %0t ns: %s is %0h, expected %0h",
                                 $time, name, got, exp));
  endtask

  task automatic check_idle_outputs();
    expect_value("flash_ce_n", flash_ce_n, 1);
    expect_value("flash_we_n", flash_we_n, 1);
    expect_value("flash_oe_n", flash_oe_n, 1);
    expect_value("flash_dq_oe", flash_dq_oe, 0);
    expect_value("prog_busy", prog_busy, 0);
    expect_value("prog_done", prog_done, 0);
    expect_value("prog_status", prog_status, 0);
  endtask

  // entered and left on a falling edge
  task automatic pulse_start(input int n);
    prog_en     = 1'b1;
    prog_addr   = t_addr[n];
    prog_length = LEN_W'(t_len[n]);
    @(negedge clk);
    prog_en = 1'b0;
    expect_value("prog_busy", prog_busy, 1);
  endtask

  task automatic run_prog(input int n);
    logic [DATA_W-1:0] words [$];
    logic [ADDR_W-1:0] a;
    int                stat0;
    int                ff0;
    int                i;
    words.delete();
    for (i = 0; i <= t_len[n]; i++)
      words.push_back(16'($urandom));
    busy_polls = t_polls[n];
    err_bits   = t_err[n];
    stat0      = u_flash.stat_reads;
    ff0        = u_flash.ff_writes;
    if (t_slow[n])
      pulse_start(n);   // buffer starts empty, sequencer must stall
    for (i = 0; i < words.size(); i++)
    begin
      buf_wr_en   = 1'b1;
      buf_wr_data = words[i];
      @(negedge clk);
      buf_wr_en = 1'b0;
      if (t_slow[n])
        repeat ($urandom_range(1, 11)) @(negedge clk);
    end
    if (!t_slow[n])
    begin
      expect_value("buf_full", buf_full, words.size() == BUF_DEPTH);
      if (words.size() == BUF_DEPTH)
      begin
        buf_wr_en   = 1'b1;   // one word too many, must be dropped
        buf_wr_data = ~words[0];
        @(negedge clk);
        buf_wr_en = 1'b0;
      end
      pulse_start(n);
    end
    do
      @(negedge clk);
    while (prog_done !== 1'b1);
    expect_value("prog_busy", prog_busy, 0);
    expect_value("prog_status", prog_status, 8'h80 | t_err[n]);
    expect_value("status reads", u_flash.stat_reads - stat0, t_polls[n] + 1);
    expect_value("read-array writes", u_flash.ff_writes - ff0, 1);
    expect_value("block address", u_flash.blk_addr, t_addr[n] & ~25'h1ffff);
    expect_value("start address", u_flash.start_addr, t_addr[n]);
    expect_value("count word", u_flash.count_word, t_len[n]);
    for (i = 0; i < words.size(); i++)
    begin
      a = t_addr[n] + ADDR_W'(i);
      expect_value($sformatf("flash_mem[%0h]", a), u_flash.mem[a], words[i]);
    end
  endtask

  assert property (@(posedge clk) disable iff (!rst_n) prog_done |=> !prog_done)
    else end_with_failure("prog_done stayed high for more than one cycle");

  assert property (@(posedge clk) !u_flash.order_err)
    else end_with_failure("flash model saw a command cycle out of order");

  assert property (@(posedge clk) !u_flash.early_poll)
    else end_with_failure("status read started before the poll wait had passed");

  initial
  begin
    void'($urandom(32'h34c343da));
    buf_wr_en   = 1'b0;
    buf_wr_data = '0;
    prog_en     = 1'b0;
    prog_addr   = '0;
    prog_length = '0;
    busy_polls  = 0;
    err_bits    = '0;
    limit_cycles = 16;
    for (int t = 0; t < N_TESTS; t++)
    begin
      t_len[t]   = $urandom_range(0, 63);
      t_addr[t]  = ADDR_W'($urandom);
      if (t_addr[t][16:0] > 17'h1ff00)
        t_addr[t][16:0] = 17'h1ff00;   // keep the run inside one block
      t_polls[t] = $urandom_range(0, 5);
      t_err[t]   = 8'h00;
      t_slow[t]  = 1'b0;
    end
    t_len[0]   = 0;
    t_polls[0] = 0;
    t_len[1]   = BUF_DEPTH - 1;   // fills the buffer exactly
    t_addr[1][16:0] = 17'h1fe00;
    t_polls[1] = 5;
    t_err[2]   = 8'h10;   // program error
    t_err[3]   = 8'h02;   // lock error
    t_err[4]   = 8'h12;
    t_slow[4]  = 1'b1;
    t_slow[5]  = 1'b1;
    for (int t = 0; t < N_TESTS; t++)
      limit_cycles += (t_len[t] + 4) * 16 + t_polls[t] * 8 + 100;
    fork
      begin
        repeat (limit_cycles) @(posedge clk);
        end_with_failure("watchdog expired before all tests finished");
      end
    join_none
    @(posedge clk);   // first clock edge inside reset
    repeat (15)
    begin
      @(negedge clk);
      check_idle_outputs();
    end
    @(posedge rst_n);
    @(negedge clk);
    check_idle_outputs();
    for (int t = 0; t < N_TESTS; t++)
      run_prog(t);
    repeat (4) @(negedge clk);
    $display("Test completed successfully");
    $finish;
  end

endmodule

// ==== all.f ====
flash_cmd_pkg.sv
flash_bus_pkg.sv
flash_bus_if.sv
prog_buf_fifo.sv
buf_prog_seq.sv
flash_bus_engine.sv
flash_prog_top.sv
tb_clk_gen.sv
tb_flash_model.sv
tb_flash_prog.sv
